// File: files.f
+incdir+.
iti_pkg.sv
itype_detector.sv
iretire_counter.sv
block_emitter.sv
iti_regs.sv
iti_top.sv
iti_asserts.sv
tb_iti.sv

// File: Makefile
TOOL       = verilator
TOP        = tb_iti
FILELIST   = files.f
OBJ_DIR    = obj_dir
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert -Mdir $(OBJ_DIR)
PASS_MSG   = TEST OK

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# build, run, and fail unless the pass line shows up
sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: tb_iti.sv
// ########################################
// directed testbench for the trace encoder
//  clock, reset, AXI4-Lite and commit tasks
//  compare tasks, timeout and summary
// ########################################

`timescale 1ns/1ps

`include "iti_consts.svh"

module tb_iti;

  import iti_pkg::*;

  // cycle estimate per test
  localparam int RESET_CYCLES = 8;
  localparam int RAND_LEN     = 200;
  localparam int T1_CYCLES    = 50;
  localparam int T2_CYCLES    = 40;
  localparam int T3_CYCLES    = 50;
  localparam int T4_CYCLES    = 30;
  localparam int T5_CYCLES    = RAND_LEN + 30;
  // twice the sum as margin
  localparam int MAX_CYCLES   = 2 * (RESET_CYCLES + T1_CYCLES + T2_CYCLES +
                                     T3_CYCLES + T4_CYCLES + T5_CYCLES);

  logic                        clk_i;
  logic                        reset_i;
  logic                        commit_valid_i;
  logic [`ITI_XLEN-1:0]        commit_iaddr_i;
  fu_op_e                      commit_op_i;
  logic                        commit_taken_i;
  logic                        commit_exc_i;
  logic                        commit_int_i;
  logic [`ITI_CAUSE_LEN-1:0]   commit_cause_i;
  logic                        trace_valid_o;
  logic [`ITI_XLEN-1:0]        trace_iaddr_o;
  logic [`ITI_IRETIRE_LEN-1:0] trace_iretire_o;
  itype_t                      trace_itype_o;
  logic [`ITI_CAUSE_LEN-1:0]   trace_cause_o;
  logic                        s_awvalid_i;
  logic [31:0]                 s_awaddr_i;
  logic                        s_awready_o;
  logic                        s_wvalid_i;
  logic [31:0]                 s_wdata_i;
  logic                        s_wready_o;
  logic                        s_bvalid_o;
  axi_resp_e                   s_bresp_o;
  logic                        s_bready_i;
  logic                        s_arvalid_i;
  logic [31:0]                 s_araddr_i;
  logic                        s_arready_o;
  logic                        s_rvalid_o;
  logic [31:0]                 s_rdata_o;
  axi_resp_e                   s_rresp_o;
  logic                        s_rready_i;

  int          checks;
  int          errors;
  int          cycles;
  int          seen_blocks;
  int          exp_blocks;
  logic [31:0] rng;

  iti_top u_dut (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .commit_valid_i  (commit_valid_i),
    .commit_iaddr_i  (commit_iaddr_i),
    .commit_op_i     (commit_op_i),
    .commit_taken_i  (commit_taken_i),
    .commit_exc_i    (commit_exc_i),
    .commit_int_i    (commit_int_i),
    .commit_cause_i  (commit_cause_i),
    .trace_valid_o   (trace_valid_o),
    .trace_iaddr_o   (trace_iaddr_o),
    .trace_iretire_o (trace_iretire_o),
    .trace_itype_o   (trace_itype_o),
    .trace_cause_o   (trace_cause_o),
    .s_awvalid_i     (s_awvalid_i),
    .s_awaddr_i      (s_awaddr_i),
    .s_awready_o     (s_awready_o),
    .s_wvalid_i      (s_wvalid_i),
    .s_wdata_i       (s_wdata_i),
    .s_wready_o      (s_wready_o),
    .s_bvalid_o      (s_bvalid_o),
    .s_bresp_o       (s_bresp_o),
    .s_bready_i      (s_bready_i),
    .s_arvalid_i     (s_arvalid_i),
    .s_araddr_i      (s_araddr_i),
    .s_arready_o     (s_arready_o),
    .s_rvalid_o      (s_rvalid_o),
    .s_rdata_o       (s_rdata_o),
    .s_rresp_o       (s_rresp_o),
    .s_rready_i      (s_rready_i)
  );

  // 40 ns period
  always #20 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles++;
    if (cycles > MAX_CYCLES) begin
      $display("run stopped after %0d cycles, tests did not finish", MAX_CYCLES);
      $display("TEST FAILED");
      $finish;
    end
  end

  // every emitted pulse, sampled mid cycle
  always @(negedge clk_i) begin
    if (!reset_i && trace_valid_o) begin
      seen_blocks++;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // closing rule: any trap, or a valid return, branch or jalr
  function automatic logic closes_block(input logic valid, input fu_op_e op,
                                        input logic exc, input logic intr);
    logic ctl;
    ctl = op inside {OP_EQ, OP_NE, OP_LTS, OP_GES, OP_LTU, OP_GEU,
                     OP_JALR, OP_MRET, OP_SRET, OP_DRET};
    return exc || intr || (valid && ctl);
  endfunction

  task automatic cmp_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
    end
  endtask

  task automatic cmp_itype(input string name, input itype_t got, input itype_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %0t %s got %s expected %s", $time, name, got.name(), exp.name());
    end
  endtask

  task automatic cmp_resp(input string name, input axi_resp_e got, input axi_resp_e exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %0t %s got %s expected %s", $time, name, got.name(), exp.name());
    end
  endtask

  task automatic print_result(input string name, input int err_before);
    if (errors == err_before) begin
      $display("%s: passed", name);
    end else begin
      $display("%s: failed with %0d errors", name, errors - err_before);
    end
  endtask

  task automatic drive_commit(input logic valid, input logic [31:0] iaddr, input fu_op_e op,
                              input logic taken, input logic exc, input logic intr,
                              input logic [`ITI_CAUSE_LEN-1:0] cause);
    @(posedge clk_i);
    commit_valid_i <= valid;
    commit_iaddr_i <= iaddr;
    commit_op_i    <= op;
    commit_taken_i <= taken;
    commit_exc_i   <= exc;
    commit_int_i   <= intr;
    commit_cause_i <= cause;
  endtask

  task automatic drive_idle();
    drive_commit(1'b0, 32'd0, OP_OTHER, 1'b0, 1'b0, 1'b0, '0);
  endtask

  // k plain commits at consecutive addresses
  task automatic drive_run(input logic [31:0] base, input int k);
    for (int i = 0; i < k; i++) begin
      drive_commit(1'b1, base + 32'(4 * i), OP_OTHER, 1'b0, 1'b0, 1'b0, '0);
    end
  endtask

  task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                           input axi_resp_e exp_resp);
    @(posedge clk_i);
    s_awvalid_i <= 1'b1;
    s_awaddr_i  <= addr;
    s_wvalid_i  <= 1'b1;
    s_wdata_i   <= data;
    // ready is combinational, look mid cycle
    @(negedge clk_i);
    while (!s_awready_o) @(negedge clk_i);
    cmp_word("s_wready_o", 32'(s_wready_o), 32'd1);
    @(posedge clk_i);
    s_awvalid_i <= 1'b0;
    s_wvalid_i  <= 1'b0;
    @(negedge clk_i);
    while (!s_bvalid_o) @(negedge clk_i);
    // response must stay up without bready
    @(negedge clk_i);
    cmp_word("s_bvalid_o", 32'(s_bvalid_o), 32'd1);
    cmp_resp("s_bresp_o", s_bresp_o, exp_resp);
    @(posedge clk_i);
    s_bready_i <= 1'b1;
    @(posedge clk_i);
    s_bready_i <= 1'b0;
  endtask

  task automatic axi_read(input logic [31:0] addr, input logic [31:0] exp_data,
                          input axi_resp_e exp_resp);
    @(posedge clk_i);
    s_arvalid_i <= 1'b1;
    s_araddr_i  <= addr;
    @(negedge clk_i);
    while (!s_arready_o) @(negedge clk_i);
    @(posedge clk_i);
    s_arvalid_i <= 1'b0;
    @(negedge clk_i);
    while (!s_rvalid_o) @(negedge clk_i);
    // response must stay up without rready
    @(negedge clk_i);
    cmp_word("s_rvalid_o", 32'(s_rvalid_o), 32'd1);
    cmp_resp("s_rresp_o", s_rresp_o, exp_resp);
    // data is only defined for OKAY
    if (exp_resp == RESP_OKAY) begin
      cmp_word("s_rdata_o", s_rdata_o, exp_data);
    end
    @(posedge clk_i);
    s_rready_i <= 1'b1;
    @(posedge clk_i);
    s_rready_i <= 1'b0;
  endtask

  // call right after the closing commit was driven
  task automatic expect_block(input itype_t exp_type, input logic [31:0] exp_iaddr,
                              input int exp_iretire, input logic [`ITI_CAUSE_LEN-1:0] exp_cause);
    exp_blocks++;
    drive_idle();
    @(negedge clk_i);
    cmp_word("trace_valid_o", 32'(trace_valid_o), 32'd1);
    cmp_itype("trace_itype_o", trace_itype_o, exp_type);
    cmp_word("trace_iaddr_o", trace_iaddr_o, exp_iaddr);
    cmp_word("trace_iretire_o", 32'(trace_iretire_o), exp_iretire);
    cmp_word("trace_cause_o", 32'(trace_cause_o), 32'(exp_cause));
    // single cycle pulse
    @(negedge clk_i);
    cmp_word("trace_valid_o", 32'(trace_valid_o), 32'd0);
  endtask

  // block of one commit, cause only kept for traps
  task automatic one_commit_block(input fu_op_e op, input logic taken, input logic exc,
                                  input logic intr, input itype_t exp_type);
    logic [31:0]               addr;
    logic [`ITI_CAUSE_LEN-1:0] cause;
    rng = xorshift32(rng);
    addr = {rng[31:2], 2'b00};
    cause = rng[6:2];
    drive_commit(1'b1, addr, op, taken, exc, intr, cause);
    expect_block(exp_type, addr, 1, (exc || intr) ? cause : '0);
  endtask

  task automatic disabled_tracing();
    int          err0;
    int          blk0;
    logic [31:0] addr;
    err0 = errors;
    blk0 = seen_blocks;
    axi_read(`ITI_REG_CTRL, 32'd0, RESP_OKAY);
    axi_read(`ITI_REG_COUNT, 32'd0, RESP_OKAY);
    rng = xorshift32(rng);
    addr = {rng[31:2], 2'b00};
    for (int i = 0; i < 3; i++) begin
      drive_commit(1'b1, addr + 32'(4 * i), OP_EQ, 1'b1, 1'b0, 1'b0, '0);
    end
    repeat (3) drive_idle();
    cmp_word("blocks while disabled", 32'(seen_blocks - blk0), 32'd0);
    axi_read(32'h0000_0008, 32'd0, RESP_SLVERR);
    axi_write(32'h0000_0010, 32'h1, RESP_SLVERR);
    // COUNT ignores writes
    axi_write(`ITI_REG_COUNT, 32'h55, RESP_OKAY);
    axi_read(`ITI_REG_COUNT, 32'd0, RESP_OKAY);
    axi_read(`ITI_REG_CTRL, 32'd0, RESP_OKAY);
    print_result("disabled tracing", err0);
  endtask

  task automatic branch_blocks();
    int          err0;
    logic [31:0] base;
    err0 = errors;
    axi_write(`ITI_REG_CTRL, 32'h1, RESP_OKAY);
    axi_read(`ITI_REG_CTRL, 32'h1, RESP_OKAY);
    rng = xorshift32(rng);
    base = {rng[31:2], 2'b00};
    drive_run(base, 3);
    drive_commit(1'b1, base + 32'd12, OP_LTU, 1'b1, 1'b0, 1'b0, '0);
    expect_block(TAKEN_BR, base, 4, '0);
    rng = xorshift32(rng);
    base = {rng[31:2], 2'b00};
    drive_run(base, 2);
    drive_commit(1'b1, base + 32'd8, OP_GES, 1'b0, 1'b0, 1'b0, '0);
    expect_block(NON_TAKEN_BR, base, 3, '0);
    print_result("branch blocks", err0);
  endtask

  task automatic priority_order();
    int          err0;
    logic [31:0] base;
    err0 = errors;
    one_commit_block(OP_MRET, 1'b1, 1'b1, 1'b1, EXC);
    one_commit_block(OP_NE, 1'b1, 1'b1, 1'b0, EXC);
    one_commit_block(OP_MRET, 1'b1, 1'b0, 1'b1, INT);
    one_commit_block(OP_MRET, 1'b1, 1'b0, 1'b0, ERET);
    one_commit_block(OP_SRET, 1'b0, 1'b0, 1'b0, ERET);
    one_commit_block(OP_DRET, 1'b0, 1'b0, 1'b0, ERET);
    one_commit_block(OP_JALR, 1'b0, 1'b0, 1'b0, UNINF_JMP);
    one_commit_block(OP_EQ, 1'b1, 1'b0, 1'b0, TAKEN_BR);
    // taken flag alone does not close a block
    rng = xorshift32(rng);
    base = {rng[31:2], 2'b00};
    drive_commit(1'b1, base, OP_OTHER, 1'b1, 1'b0, 1'b0, '0);
    drive_commit(1'b1, base + 32'd4, OP_NE, 1'b1, 1'b0, 1'b0, '0);
    expect_block(TAKEN_BR, base, 2, '0);
    print_result("priority order", err0);
  endtask

  task automatic traps_without_commit();
    int                        err0;
    logic [31:0]               base;
    logic [31:0]               addr;
    logic [`ITI_CAUSE_LEN-1:0] cause;
    err0 = errors;
    rng = xorshift32(rng);
    base = {rng[31:2], 2'b00};
    drive_run(base, 2);
    rng = xorshift32(rng);
    addr = {rng[31:2], 2'b00};
    cause = rng[4:0];
    drive_commit(1'b0, addr, OP_OTHER, 1'b0, 1'b0, 1'b1, cause);
    expect_block(INT, base, 2, cause);
    // block is empty now, current address reported
    rng = xorshift32(rng);
    addr = {rng[31:2], 2'b00};
    cause = rng[4:0];
    drive_commit(1'b0, addr, OP_OTHER, 1'b0, 1'b0, 1'b1, cause);
    expect_block(INT, addr, 0, cause);
    drive_run(base, 1);
    drive_commit(1'b0, addr, OP_OTHER, 1'b0, 1'b1, 1'b0, cause);
    expect_block(EXC, base, 1, cause);
    print_result("traps without commit", err0);
  endtask

  task automatic block_counter();
    int     err0;
    logic   valid;
    fu_op_e op;
    logic   exc;
    logic   intr;
    err0 = errors;
    for (int i = 0; i < RAND_LEN; i++) begin
      rng = xorshift32(rng);
      valid = rng[0] | rng[1];
      op = fu_op_e'(rng[7:4] % 4'd11);
      // traps are rare
      exc = (rng[11:8] == 4'd0);
      intr = (rng[15:12] == 4'd0);
      if (closes_block(valid, op, exc, intr)) begin
        exp_blocks++;
      end
      drive_commit(valid, {rng[31:2], 2'b00}, op, rng[3], exc, intr, rng[20:16]);
    end
    // let the last pulse reach the counter
    repeat (3) drive_idle();
    axi_read(`ITI_REG_COUNT, 32'(exp_blocks), RESP_OKAY);
    cmp_word("trace pulses seen", 32'(seen_blocks), 32'(exp_blocks));
    print_result("block counter", err0);
  endtask

  initial begin
    clk_i          = 1'b0;
    reset_i        = 1'b1;
    commit_valid_i = 1'b0;
    commit_iaddr_i = '0;
    commit_op_i    = OP_OTHER;
    commit_taken_i = 1'b0;
    commit_exc_i   = 1'b0;
    commit_int_i   = 1'b0;
    commit_cause_i = '0;
    s_awvalid_i    = 1'b0;
    s_awaddr_i     = '0;
    s_wvalid_i     = 1'b0;
    s_wdata_i      = '0;
    s_bready_i     = 1'b0;
    s_arvalid_i    = 1'b0;
    s_araddr_i     = '0;
    s_rready_i     = 1'b0;
    checks         = 0;
    errors         = 0;
    cycles         = 0;
    seen_blocks    = 0;
    exp_blocks     = 0;
    rng            = 32'h12535181;
    repeat (RESET_CYCLES) @(posedge clk_i);
    reset_i <= 1'b0;

    disabled_tracing();
    branch_blocks();
    priority_order();
    traps_without_commit();
    block_counter();

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: iti_asserts.sv
// ########################################
// bound checks on the trace encoder top
//  trace block type and enable
//  AXI4-Lite response hold
// ########################################

`timescale 1ns/1ps

module iti_asserts (
  input logic            clk_i,
  input logic            reset_i,
  input logic            trace_en_i,
  input logic            trace_valid_i,
  input iti_pkg::itype_t trace_itype_i,
  input logic            bvalid_i,
  input logic            bready_i,
  input logic            rvalid_i,
  input logic            rready_i
);

  import iti_pkg::*;

  // a block always carries a boundary type
  a_no_standard: assert property (@(posedge clk_i) disable iff (reset_i)
    trace_valid_i |-> (trace_itype_i != STANDARD))
    else $error("trace block emitted with itype STANDARD");

  a_bvalid_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    (bvalid_i && !bready_i) |=> bvalid_i)
    else $error("bvalid dropped before bready");

  a_rvalid_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    (rvalid_i && !rready_i) |=> rvalid_i)
    else $error("rvalid dropped before rready");

  // pulse comes from a close one edge earlier
  a_only_enabled: assert property (@(posedge clk_i) disable iff (reset_i)
    trace_valid_i |-> $past(trace_en_i))
    else $error("trace block emitted while tracing disabled");

endmodule

bind iti_top iti_asserts u_asserts (
  .clk_i         (clk_i),
  .reset_i       (reset_i),
  .trace_en_i    (trace_en),
  .trace_valid_i (trace_valid_o),
  .trace_itype_i (trace_itype_o),
  .bvalid_i      (s_bvalid_o),
  .bready_i      (s_bready_i),
  .rvalid_i      (s_rvalid_o),
  .rready_i      (s_rready_i)
);

// File: iti_top.sv
// ########################################
// trace encoder front end top level
//  itype detector, retire counter,
//  block emitter and config slave
// ########################################

`timescale 1ns/1ps

`include "iti_consts.svh"

module iti_top (
  input  logic                        clk_i,
  input  logic                        reset_i,
  // commit stage
  input  logic                        commit_valid_i,
  input  logic [`ITI_XLEN-1:0]        commit_iaddr_i,
  input  iti_pkg::fu_op_e             commit_op_i,
  input  logic                        commit_taken_i,
  input  logic                        commit_exc_i,
  input  logic                        commit_int_i,
  input  logic [`ITI_CAUSE_LEN-1:0]   commit_cause_i,
  // trace blocks, no back-pressure
  output logic                        trace_valid_o,
  output logic [`ITI_XLEN-1:0]        trace_iaddr_o,
  output logic [`ITI_IRETIRE_LEN-1:0] trace_iretire_o,
  output iti_pkg::itype_t             trace_itype_o,
  output logic [`ITI_CAUSE_LEN-1:0]   trace_cause_o,
  // config port
  input  logic                        s_awvalid_i,
  input  logic [31:0]                 s_awaddr_i,
  output logic                        s_awready_o,
  input  logic                        s_wvalid_i,
  input  logic [31:0]                 s_wdata_i,
  output logic                        s_wready_o,
  output logic                        s_bvalid_o,
  output iti_pkg::axi_resp_e          s_bresp_o,
  input  logic                        s_bready_i,
  input  logic                        s_arvalid_i,
  input  logic [31:0]                 s_araddr_i,
  output logic                        s_arready_o,
  output logic                        s_rvalid_o,
  output logic [31:0]                 s_rdata_o,
  output iti_pkg::axi_resp_e          s_rresp_o,
  input  logic                        s_rready_i
);

  import iti_pkg::*;

  itype_t                      itype;
  logic [`ITI_XLEN-1:0]        blk_iaddr;
  logic [`ITI_IRETIRE_LEN-1:0] blk_iretire;
  logic                        restart;
  logic                        trace_en;

  itype_detector #(
    .ITYPE_LEN (`ITI_ITYPE_LEN)
  ) u_itype_detector (
    .valid_i        (commit_valid_i),
    .exception_i    (commit_exc_i),
    .interrupt_i    (commit_int_i),
    .op_i           (commit_op_i),
    .branch_taken_i (commit_taken_i),
    .itype_o        (itype)
  );

  iretire_counter u_iretire_counter (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .valid_i       (commit_valid_i),
    .iaddr_i       (commit_iaddr_i),
    .restart_i     (restart),
    .blk_iaddr_o   (blk_iaddr),
    .blk_iretire_o (blk_iretire)
  );

  block_emitter u_block_emitter (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .trace_en_i      (trace_en),
    .itype_i         (itype),
    .blk_iaddr_i     (blk_iaddr),
    .blk_iretire_i   (blk_iretire),
    .cause_i         (commit_cause_i),
    .restart_o       (restart),
    .trace_valid_o   (trace_valid_o),
    .trace_iaddr_o   (trace_iaddr_o),
    .trace_iretire_o (trace_iretire_o),
    .trace_itype_o   (trace_itype_o),
    .trace_cause_o   (trace_cause_o)
  );

  // emitted blocks are counted from the trace pulse
  iti_regs u_iti_regs (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .s_awvalid_i   (s_awvalid_i),
    .s_awaddr_i    (s_awaddr_i),
    .s_awready_o   (s_awready_o),
    .s_wvalid_i    (s_wvalid_i),
    .s_wdata_i     (s_wdata_i),
    .s_wready_o    (s_wready_o),
    .s_bvalid_o    (s_bvalid_o),
    .s_bresp_o     (s_bresp_o),
    .s_bready_i    (s_bready_i),
    .s_arvalid_i   (s_arvalid_i),
    .s_araddr_i    (s_araddr_i),
    .s_arready_o   (s_arready_o),
    .s_rvalid_o    (s_rvalid_o),
    .s_rdata_o     (s_rdata_o),
    .s_rresp_o     (s_rresp_o),
    .s_rready_i    (s_rready_i),
    .trace_valid_i (trace_valid_o),
    .trace_en_o    (trace_en)
  );

endmodule

// File: iti_regs.sv
// ########################################
// AXI4-Lite config slave
//  CTRL  bit 0 enables tracing
//  COUNT emitted trace blocks, read only
//  one outstanding transfer at a time
// ########################################

`timescale 1ns/1ps

`include "iti_consts.svh"

module iti_regs (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                s_awvalid_i,
  input  logic [31:0]         s_awaddr_i,
  output logic                s_awready_o,
  input  logic                s_wvalid_i,
  input  logic [31:0]         s_wdata_i,
  output logic                s_wready_o,
  output logic                s_bvalid_o,
  output iti_pkg::axi_resp_e  s_bresp_o,
  input  logic                s_bready_i,
  input  logic                s_arvalid_i,
  input  logic [31:0]         s_araddr_i,
  output logic                s_arready_o,
  output logic                s_rvalid_o,
  output logic [31:0]         s_rdata_o,
  output iti_pkg::axi_resp_e  s_rresp_o,
  input  logic                s_rready_i,
  input  logic                trace_valid_i,
  output logic                trace_en_o
);

  import iti_pkg::*;

  axi_state_e  state_q;
  logic        wr_req;
  logic        wr_acc;
  logic        rd_acc;
  logic [31:0] blk_cnt_q;
  logic [31:0] rd_data;
  axi_resp_e   rd_resp;

  // address and data must arrive together
  assign wr_req = s_awvalid_i && s_wvalid_i;
  assign wr_acc = (state_q == AXI_IDLE) && wr_req;
  // writes win over reads in the same cycle
  assign rd_acc = (state_q == AXI_IDLE) && !wr_req && s_arvalid_i;

  assign s_awready_o = wr_acc;
  assign s_wready_o  = wr_acc;
  assign s_arready_o = rd_acc;
  assign s_bvalid_o  = (state_q == AXI_WRESP);
  assign s_rvalid_o  = (state_q == AXI_RDATA);

  // read decode
  always_comb begin
    rd_data = '0;
    rd_resp = RESP_OKAY;
    if (s_araddr_i == `ITI_REG_CTRL) begin
      rd_data = {31'd0, trace_en_o};
    end else if (s_araddr_i == `ITI_REG_COUNT) begin
      rd_data = blk_cnt_q;
    end else begin
      rd_resp = RESP_SLVERR;
    end
  end

  // handshake FSM and enable bit
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q    <= AXI_IDLE;
      trace_en_o <= 1'b0;
    end else begin
      case (state_q)
        AXI_IDLE: begin
          if (wr_acc) begin
            state_q <= AXI_WRESP;
            if (s_awaddr_i == `ITI_REG_CTRL) begin
              trace_en_o <= s_wdata_i[0];
            end
          end else if (rd_acc) begin
            state_q <= AXI_RDATA;
          end
        end
        // hold response until the master takes it
        AXI_WRESP: if (s_bready_i) state_q <= AXI_IDLE;
        AXI_RDATA: if (s_rready_i) state_q <= AXI_IDLE;
        default:   state_q <= AXI_IDLE;
      endcase
    end
  end

  // response payload, captured at acceptance
  always_ff @(posedge clk_i) begin
    if (wr_acc) begin
      // COUNT is read only, write dropped silently
      s_bresp_o <= ((s_awaddr_i == `ITI_REG_CTRL) || (s_awaddr_i == `ITI_REG_COUNT)) ?
                   RESP_OKAY : RESP_SLVERR;
    end
    if (rd_acc) begin
      s_rdata_o <= rd_data;
      s_rresp_o <= rd_resp;
    end
  end

  // emitted block counter, wraps at 2^32
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      blk_cnt_q <= '0;
    end else if (trace_valid_i) begin
      blk_cnt_q <= blk_cnt_q + 32'd1;
    end
  end

endmodule

// File: block_emitter.sv
// ########################################
// trace block output stage
//  decides when a block closes
//  registers the emitted block fields
// ########################################

`timescale 1ns/1ps

`include "iti_consts.svh"

module block_emitter (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        trace_en_i,
  input  iti_pkg::itype_t             itype_i,
  input  logic [`ITI_XLEN-1:0]        blk_iaddr_i,
  input  logic [`ITI_IRETIRE_LEN-1:0] blk_iretire_i,
  input  logic [`ITI_CAUSE_LEN-1:0]   cause_i,
  output logic                        restart_o,
  output logic                        trace_valid_o,
  output logic [`ITI_XLEN-1:0]        trace_iaddr_o,
  output logic [`ITI_IRETIRE_LEN-1:0] trace_iretire_o,
  output iti_pkg::itype_t             trace_itype_o,
  output logic [`ITI_CAUSE_LEN-1:0]   trace_cause_o
);

  import iti_pkg::*;

  logic is_boundary;
  logic close_blk;
  logic is_trap;

  // any non STANDARD itype ends a block
  assign is_boundary = (itype_i != STANDARD);
  assign close_blk   = trace_en_i && is_boundary;

  // counter drops its block when tracing is off as well
  assign restart_o = !trace_en_i || is_boundary;

  // cause field is only meaningful for traps
  assign is_trap = (itype_i == EXC) || (itype_i == INT);

  // one cycle pulse per closed block
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      trace_valid_o <= 1'b0;
    end else begin
      trace_valid_o <= close_blk;
    end
  end

  // fields hold until the next block closes
  always_ff @(posedge clk_i) begin
    if (close_blk) begin
      trace_iaddr_o   <= blk_iaddr_i;
      trace_iretire_o <= blk_iretire_i;
      trace_itype_o   <= itype_i;
      trace_cause_o   <= is_trap ? cause_i : '0;
    end
  end

endmodule

// File: iretire_counter.sv
// ########################################
// current block tracking
//  start address and retired count
//  block view as if closed at this commit
// ########################################

`timescale 1ns/1ps

`include "iti_consts.svh"

module iretire_counter (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        valid_i,
  input  logic [`ITI_XLEN-1:0]        iaddr_i,
  input  logic                        restart_i,
  output logic [`ITI_XLEN-1:0]        blk_iaddr_o,
  output logic [`ITI_IRETIRE_LEN-1:0] blk_iretire_o
);

  logic [`ITI_XLEN-1:0]        start_q;
  logic [`ITI_IRETIRE_LEN-1:0] count_q;
  logic                        empty_q;

  // empty block starts at the current commit
  assign blk_iaddr_o = empty_q ? iaddr_i : start_q;

  // current commit counts into the closing block
  assign blk_iretire_o = count_q + {{(`ITI_IRETIRE_LEN-1){1'b0}}, valid_i};

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_q <= '0;
      empty_q <= 1'b1;
    end else if (restart_i) begin
      // block closed or tracing off
      count_q <= '0;
      empty_q <= 1'b1;
    end else if (valid_i) begin
      count_q <= count_q + 1'b1;
      empty_q <= 1'b0;
    end
  end

  // first valid commit of a block sets its start
  always_ff @(posedge clk_i) begin
    if (!restart_i && valid_i && empty_q) begin
      start_q <= iaddr_i;
    end
  end

endmodule

// File: itype_detector.sv
// ########################################
// itype classifier
//  one commit in, one instruction type out
//  purely combinational
// ########################################

`timescale 1ns/1ps

`include "iti_consts.svh"

module itype_detector #(
  // itype_width_p of the spec, 3 or 4
  parameter int ITYPE_LEN = `ITI_ITYPE_LEN
) (
  input  logic             valid_i,
  input  logic             exception_i,
  input  logic             interrupt_i,
  input  iti_pkg::fu_op_e  op_i,
  input  logic             branch_taken_i,
  output iti_pkg::itype_t  itype_o
);

  import iti_pkg::*;

  logic is_ret;
  logic is_cmp;
  logic is_jalr;

  // xRET of any privilege level
  assign is_ret = (op_i == OP_MRET) || (op_i == OP_SRET) || (op_i == OP_DRET);

  // conditional branches, taken or not
  assign is_cmp = (op_i == OP_EQ)  || (op_i == OP_NE)  ||
                  (op_i == OP_LTS) || (op_i == OP_GES) ||
                  (op_i == OP_LTU) || (op_i == OP_GEU);

  // indirect jump, target not inferable from the binary
  assign is_jalr = (op_i == OP_JALR);

  always_comb begin
    itype_o = STANDARD;
    // traps need no committed instruction
    if (exception_i) begin
      itype_o = EXC;
    end else if (interrupt_i) begin
      itype_o = INT;
    end else if (valid_i && is_ret) begin
      itype_o = ERET;
    end else if (valid_i && is_cmp) begin
      // taken flag picks between the two branch codes
      itype_o = branch_taken_i ? TAKEN_BR : NON_TAKEN_BR;
    end else if (valid_i && is_jalr && (ITYPE_LEN == 3)) begin
      // 4 bit itype has its own jump codes
      itype_o = UNINF_JMP;
    end
  end

endmodule

// File: iti_pkg.sv
// ########################################
// trace encoder types
//  commit opcode classes
//  instruction types
//  AXI4-Lite slave states and responses
// ########################################

`include "iti_consts.svh"

package iti_pkg;

  // operation class of a retired instruction
  typedef enum logic [3:0] {
    OP_OTHER,
    OP_EQ,
    OP_NE,
    OP_LTS,
    OP_GES,
    OP_LTU,
    OP_GEU,
    OP_JALR,
    OP_MRET,
    OP_SRET,
    OP_DRET
  } fu_op_e;

  // E-Trace itype, 3 bit variant
  typedef enum logic [`ITI_ITYPE_LEN-1:0] {
    STANDARD     = 3'd0,
    EXC          = 3'd1,
    INT          = 3'd2,
    ERET         = 3'd3,
    NON_TAKEN_BR = 3'd4,
    TAKEN_BR     = 3'd5,
    UNINF_JMP    = 3'd6
  } itype_t;

  // config slave FSM
  typedef enum logic [1:0] {
    AXI_IDLE,
    AXI_WRESP,
    AXI_RDATA
  } axi_state_e;

  // only OKAY and SLVERR are ever returned
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axi_resp_e;

endpackage

// File: iti_consts.svh
// ########################################
// widths of the trace encoder datapath
// and byte offsets of the config registers
// ########################################

`ifndef ITI_CONSTS_SVH
`define ITI_CONSTS_SVH

// instruction address width
`define ITI_XLEN 32
// trap cause width
`define ITI_CAUSE_LEN 5
// retired instruction count, wraps
`define ITI_IRETIRE_LEN 16
// itype width, 3 or 4 in E-Trace
`define ITI_ITYPE_LEN 3

// register map on the AXI4-Lite port
`define ITI_REG_CTRL 32'h0000_0000
`define ITI_REG_COUNT 32'h0000_0004

`endif
